// ==== common/cpuControlPkg.sv ====
`default_nettype none

package cpuControlPkg;

   typedef logic [7:0] instrByteT;    // Opcode in [7:3], condition or sub-code in [2:0]
   typedef logic [3:0] flagsT;

   localparam int FlagC = 1;          // Carry position in the ALU flag vector

   typedef enum logic [4:0] {
      ADD    = 5'h00,
      ADDI   = 5'h01,
      ADDIB  = 5'h02,
      ADC    = 5'h03,
      ADCI   = 5'h04,
      SUB    = 5'h05,
      SUBI   = 5'h06,
      SUBIB  = 5'h07,
      SUC    = 5'h08,
      SUCI   = 5'h09,
      CMP    = 5'h0a,
      CMPI   = 5'h0b,
      AND    = 5'h0c,
      OR     = 5'h0d,
      XOR    = 5'h0e,
      NOT    = 5'h0f,
      NAND   = 5'h10,
      NOR    = 5'h11,
      NEG    = 5'h12,
      LSL    = 5'h13,
      LSR    = 5'h14,
      ASR    = 5'h15,
      LUI    = 5'h16,
      LLI    = 5'h17,
      LDW    = 5'h18,
      STW    = 5'h19,
      BRANCH = 5'h1c
   } opcodeT;

   // Only the unconditional sub-codes remain, the rest advance the PC
   typedef enum logic [2:0] {
      RET = 3'd6,
      JMP = 3'd7
   } branchCodeT;

   typedef enum logic [3:0] {
      FnNOP, FnADD, FnADC, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnIMM, FnMEM
   } aluFnT;

   typedef enum logic       {Op1Rd1} op1SelT;
   typedef enum logic       {Op2Imm, Op2Rd2} op2SelT;
   typedef enum logic       {WdAlu, WdSys} wdSelT;        // Write data from ALU or system bus
   typedef enum logic       {ImmLong, ImmShort} immSelT;
   typedef enum logic [1:0] {Pc1, PcSysbus, PcAluOut} pcSelT;
   typedef enum logic       {LrSys} lrSelT;
   typedef enum logic       {Rs1Ra, Rs1Rd} rs1SelT;

   typedef enum logic       {Fetch, Execute} phaseT;
   typedef enum logic [1:0] {Fet1, Fet2, Fet3, Fet4} fetchStepT;
   typedef enum logic [2:0] {Exe1, Exe2, Exe3, Exe4, Exe5} execStepT;

endpackage

`default_nettype wire

// ==== common/stepIf.sv ====
`default_nettype none

// Sequencer position and the decoded instruction fields
interface stepIf;
   import cpuControlPkg::*;

   phaseT      phase;
   fetchStepT  fetchStep;
   execStepT   execStep;
   opcodeT     opcode;
   branchCodeT branchCode;

   modport seq (output phase, fetchStep, execStep, opcode, branchCode);
   modport dec (input phase, fetchStep, execStep, opcode, branchCode);

endinterface

`default_nettype wire

// ==== hw/cycleSequencer.sv ====
`default_nettype none

module cycleSequencer (
   input  wire                           Clock,
   input  wire                           nReset,
   input  wire cpuControlPkg::instrByteT OpcodeCondIn,
   stepIf.seq                            Step
);
   import cpuControlPkg::*;

   phaseT     phase;
   fetchStepT fetchStep;
   execStepT  execStep;
   opcodeT    opcode;
   logic      memOp;
   logic      lastExec;

   assign opcode   = opcodeT'(OpcodeCondIn[7:3]);
   assign memOp    = (opcode == LDW) || (opcode == STW);
   assign lastExec = (execStep == Exe5) || !memOp;   // Loads and stores run to Exe5

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase     <= Fetch;
         fetchStep <= Fet1;
         execStep  <= Exe1;
      end else if (phase == Fetch) begin
         fetchStep <= fetchStepT'(fetchStep + 2'd1);   // Wraps back to Fet1 after Fet4
         if (fetchStep == Fet4) begin
            phase    <= Execute;
            execStep <= Exe1;
         end
      end else if (lastExec) begin
         phase <= Fetch;
      end else begin
         execStep <= execStepT'(execStep + 3'd1);
      end
   end

   assign Step.phase      = phase;
   assign Step.fetchStep  = fetchStep;
   assign Step.execStep   = execStep;
   assign Step.opcode     = opcode;
   assign Step.branchCode = branchCodeT'(OpcodeCondIn[2:0]);

endmodule

`default_nettype wire

// ==== decode/busCycleDecoder.sv ====
`default_nettype none

module busCycleDecoder (
   stepIf.dec   Step,
   output logic MemEn,
   output logic nWE,
   output logic nOE,
   output logic nME,
   output logic ENB,
   output logic ALE,
   output logic IrWe,
   output logic PcEn
);
   import cpuControlPkg::*;

   logic isLoad;
   logic isStore;

   assign isLoad  = (Step.opcode == LDW);
   assign isStore = (Step.opcode == STW);

   always_comb begin
      MemEn = 1'b0;
      nWE   = 1'b0;
      nOE   = 1'b0;
      nME   = 1'b0;
      ENB   = 1'b0;
      ALE   = 1'b0;
      IrWe  = 1'b0;
      PcEn  = 1'b0;
      if (Step.phase == Fetch) begin
         case (Step.fetchStep)
            Fet1: begin   // PC out as the fetch address
               ALE  = 1'b1;
               nME  = 1'b1;
               nWE  = 1'b1;
               nOE  = 1'b1;
               PcEn = 1'b1;
            end
            Fet2: begin
               nWE   = 1'b1;
               MemEn = 1'b1;
            end
            Fet3: begin
               MemEn = 1'b1;
               ENB   = 1'b1;   // Instruction onto the system bus
               nWE   = 1'b1;
            end
            default: begin
               nME   = 1'b1;
               nWE   = 1'b1;
               MemEn = 1'b1;
               IrWe  = 1'b1;
            end
         endcase
      end else begin
         case (Step.execStep)
            Exe1: begin
               nME  = 1'b1;
               PcEn = !(isLoad || isStore);
            end
            Exe2: begin   // Effective address latched
               nME = isLoad || isStore;
               ALE = isLoad || isStore;
               nWE = isLoad || isStore;
               nOE = isLoad || isStore;
            end
            Exe3: begin
               MemEn = isLoad;
               nOE   = isStore;
               nWE   = isLoad || isStore;
            end
            Exe4: begin
               MemEn = isLoad;
               ENB   = isLoad;   // Read data onto the bus
               nWE   = isLoad;
               nOE   = isStore;
            end
            default: begin
               nME   = isLoad || isStore;
               nWE   = isLoad;
               MemEn = isLoad;
               nOE   = isStore;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== decode/datapathDecoder.sv ====
`default_nettype none

module datapathDecoder (
   input  wire                        Clock,
   input  wire                        nReset,
   input  wire cpuControlPkg::flagsT  Flags,
   stepIf.dec                         Step,
   output cpuControlPkg::aluFnT       AluOp,
   output cpuControlPkg::op1SelT      Op1Sel,
   output cpuControlPkg::op2SelT      Op2Sel,
   output logic                       AluEn,
   output logic                       AluWe,
   output logic                       SpEn,
   output logic                       SpWe,
   output logic                       LrEn,
   output logic                       LrWe,
   output cpuControlPkg::lrSelT       LrSel,
   output logic                       PcWe,
   output cpuControlPkg::pcSelT       PcSel,
   output cpuControlPkg::wdSelT       WdSel,
   output cpuControlPkg::immSelT      ImmSel,
   output cpuControlPkg::rs1SelT      Rs1Sel,
   output logic                       RegWe,
   output logic                       CFlag
);
   import cpuControlPkg::*;

   flagsT statusReg;
   logic  statusWe;
   aluFnT aluFn;
   logic  memOp;

   // ALU function of the single-cycle arithmetic and logic opcodes
   function automatic aluFnT aluFunction(input opcodeT op);
      case (op)
         ADD, ADDI, ADDIB:            return FnADD;
         ADC, ADCI, SUC, SUCI:        return FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         AND:                         return FnAND;
         OR:                          return FnOR;
         XOR:                         return FnXOR;
         NOT:                         return FnNOT;
         NAND:                        return FnNAND;
         NOR:                         return FnNOR;
         NEG:                         return FnNEG;
         LSL:                         return FnLSL;
         LSR:                         return FnLSR;
         ASR:                         return FnASR;
         default:                     return FnNOP;
      endcase
   endfunction

   assign aluFn = aluFunction(Step.opcode);
   assign memOp = (Step.opcode == LDW) || (Step.opcode == STW);

   always_comb begin
      AluOp    = FnNOP;
      Op1Sel   = Op1Rd1;
      Op2Sel   = Op2Imm;
      AluEn    = 1'b0;
      AluWe    = 1'b0;
      LrWe     = 1'b0;
      LrSel    = LrSys;
      PcWe     = 1'b0;
      PcSel    = Pc1;
      WdSel    = WdAlu;
      ImmSel   = ImmLong;
      Rs1Sel   = Rs1Ra;
      RegWe    = 1'b0;
      statusWe = 1'b0;
      if (Step.phase == Execute) begin
         case (Step.execStep)
            Exe1: begin
               case (Step.opcode)
                  ADD, SUB, CMP, AND, OR, XOR, NAND, NOR: Op2Sel = Op2Rd2;
                  ADDI, SUBI, CMPI, ADCI, SUCI, LSL, LSR, ASR: ImmSel = ImmShort;
                  ADDIB, SUBIB: Rs1Sel = Rs1Rd;
                  default: ;
               endcase
               PcWe = !memOp;   // Everything but LDW/STW retires here
               if (aluFn != FnNOP) begin
                  AluOp    = aluFn;
                  statusWe = 1'b1;
                  RegWe    = (Step.opcode != CMP) && (Step.opcode != CMPI);
               end else if (memOp) begin   // Base plus offset, held for Exe2
                  AluOp  = FnADD;
                  ImmSel = ImmShort;
                  AluEn  = 1'b1;
                  AluWe  = 1'b1;
               end else if ((Step.opcode == LUI) || (Step.opcode == LLI)) begin
                  AluOp = FnIMM;
                  AluEn = 1'b1;
                  RegWe = 1'b1;
               end else if (Step.opcode == BRANCH) begin
                  case (Step.branchCode)
                     RET: begin
                        LrWe  = 1'b1;
                        PcSel = PcSysbus;
                     end
                     JMP: begin
                        AluOp  = FnADD;
                        ImmSel = ImmShort;
                        PcSel  = PcAluOut;
                     end
                     default: ;
                  endcase
               end
            end
            Exe2: begin
               AluOp  = FnADD;
               ImmSel = ImmShort;
               AluEn  = memOp;
            end
            Exe3: begin   // Store data or load target through the ALU
               AluOp  = FnMEM;
               Rs1Sel = Rs1Rd;
               AluEn  = memOp;
               AluWe  = memOp;
            end
            Exe4: AluEn = (Step.opcode == STW);
            default: begin
               PcWe  = 1'b1;
               AluEn = (Step.opcode == STW);
               if (Step.opcode == LDW) begin
                  WdSel = WdSys;   // Load data from the bus
                  RegWe = 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= Flags;
      end
   end

   assign CFlag = statusReg[FlagC];

   // No stack pointer or link-register reads in this instruction set
   assign SpEn = 1'b0;
   assign SpWe = 1'b0;
   assign LrEn = 1'b0;

endmodule

`default_nettype wire

// ==== hw/controlTop.sv ====
`default_nettype none

module controlTop (
   input  wire                        Clock,
   input  wire                        nReset,
   input  wire cpuControlPkg::instrByteT OpcodeCondIn,
   input  wire cpuControlPkg::flagsT  Flags,
   output cpuControlPkg::aluFnT       AluOp,
   output cpuControlPkg::op1SelT      Op1Sel,
   output cpuControlPkg::op2SelT      Op2Sel,
   output logic                       AluEn,
   output logic                       AluWe,
   output logic                       SpEn,
   output logic                       SpWe,
   output logic                       LrEn,
   output logic                       LrWe,
   output cpuControlPkg::lrSelT       LrSel,
   output logic                       PcWe,
   output logic                       PcEn,
   output cpuControlPkg::pcSelT       PcSel,
   output logic                       IrWe,
   output cpuControlPkg::wdSelT       WdSel,
   output cpuControlPkg::immSelT      ImmSel,
   output cpuControlPkg::rs1SelT      Rs1Sel,
   output logic                       RegWe,
   output logic                       MemEn,    // Pad control
   output logic                       nWE,
   output logic                       nOE,
   output logic                       nME,
   output logic                       ENB,
   output logic                       ALE,
   output logic                       CFlag
);

   stepIf stepBus ();

   cycleSequencer sequencer0 (
      .Clock        (Clock),
      .nReset       (nReset),
      .OpcodeCondIn (OpcodeCondIn),
      .Step         (stepBus.seq)
   );

   busCycleDecoder busDecoder0 (
      .Step  (stepBus.dec),
      .MemEn (MemEn),
      .nWE   (nWE),
      .nOE   (nOE),
      .nME   (nME),
      .ENB   (ENB),
      .ALE   (ALE),
      .IrWe  (IrWe),
      .PcEn  (PcEn)
   );

   datapathDecoder dpDecoder0 (
      .Clock  (Clock),
      .nReset (nReset),
      .Flags  (Flags),
      .Step   (stepBus.dec),
      .AluOp  (AluOp),
      .Op1Sel (Op1Sel),
      .Op2Sel (Op2Sel),
      .AluEn  (AluEn),
      .AluWe  (AluWe),
      .SpEn   (SpEn),
      .SpWe   (SpWe),
      .LrEn   (LrEn),
      .LrWe   (LrWe),
      .LrSel  (LrSel),
      .PcWe   (PcWe),
      .PcSel  (PcSel),
      .WdSel  (WdSel),
      .ImmSel (ImmSel),
      .Rs1Sel (Rs1Sel),
      .RegWe  (RegWe),
      .CFlag  (CFlag)
   );

endmodule

`default_nettype wire

// ==== testbench/controlTop_properties.sv ====
`default_nettype none

module controlTopProperties (
   input wire Clock,
   input wire nReset,
   input wire ALE,
   input wire ENB,
   input wire RegWe,
   input wire IrWe,
   input wire PcWe
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [3:0] sinceIrWe;   // Cycles since the IrWe that still waits for PcWe
   logic       pcPending;   // IrWe seen, PcWe not yet

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pcPending <= 1'b0;
         sinceIrWe <= '0;
      end else if (pcPending) begin
         if (PcWe) begin
            pcPending <= 1'b0;
         end else begin
            sinceIrWe <= sinceIrWe + 4'd1;   // A later IrWe does not restart the count
         end
      end else if (IrWe) begin
         pcPending <= 1'b1;
         sinceIrWe <= 4'd1;
      end
   end

   aleEnbExclusive: assert property (@(posedge Clock) disable iff (!nReset) !(ALE && ENB))
      else $error("ALE and ENB are high in the same cycle");

   regWeApartFromIrWe: assert property (@(posedge Clock) disable iff (!nReset) !(RegWe && IrWe))
      else $error("RegWe and IrWe are high in the same cycle");

   pcWeAfterIrWe: assert property (@(posedge Clock) disable iff (!nReset)
         !(pcPending && (sinceIrWe >= 4'd9) && !PcWe))
      else $error("No PcWe within nine cycles of IrWe");

endmodule

`default_nettype wire

// ==== testbench/controlTb.sv ====
`default_nettype none

module controlTb;
   timeunit 1ns;
   timeprecision 1ps;
   import cpuControlPkg::*;

   localparam int FieldsPerLine = 7;   // Opcode, flags, AluOp, RegWe, PcSel, status, length
   localparam int MaxLines      = 48;

   logic      Clock = 1'b0;
   logic      nReset;
   instrByteT OpcodeCondIn;
   flagsT     Flags;
   aluFnT     AluOp;
   op1SelT    Op1Sel;
   op2SelT    Op2Sel;
   lrSelT     LrSel;
   pcSelT     PcSel;
   wdSelT     WdSel;
   immSelT    ImmSel;
   rs1SelT    Rs1Sel;
   logic      AluEn, AluWe, SpEn, SpWe, LrEn, LrWe;
   logic      PcWe, PcEn, IrWe, RegWe, CFlag;
   logic      MemEn, nWE, nOE, nME, ENB, ALE;

   logic [7:0]  patternMem [0:MaxLines * FieldsPerLine - 1];
   logic [31:0] rngState = 32'h6bfd;
   logic        cFlagModel;   // Carry the status register should hold
   int          cycleCount = 0;
   int          cycleLimit = 0;

   controlTop dut0 (.*);

   bind controlTop controlTopProperties props0 (
      .Clock  (Clock),
      .nReset (nReset),
      .ALE    (ALE),
      .ENB    (ENB),
      .RegWe  (RegWe),
      .IrWe   (IrWe),
      .PcWe   (PcWe)
   );

   always #5 Clock = ~Clock;

   always @(posedge Clock) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > cycleLimit) begin
         stopWithFailure($sformatf("Timeout after %0d cycles, patterns not finished", cycleCount));
      end
   end

   task automatic stopWithFailure(input string reason);
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
      if (actual !== expected) begin
         stopWithFailure($sformatf("ERR %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic flagsT randomFlags();
      rngState = xorshift32(rngState);
      return rngState[3:0];
   endfunction

   task automatic nextDrivePoint();
      @(posedge Clock);
      #1;
   endtask

   // Outputs that never change in this instruction set
   task automatic checkFixedOutputs();
      checkValue("SpEn", 8'(SpEn), 8'h00);
      checkValue("SpWe", 8'(SpWe), 8'h00);
      checkValue("LrEn", 8'(LrEn), 8'h00);
      checkValue("Op1Sel", 8'(Op1Sel), 8'(Op1Rd1));
      checkValue("LrSel", 8'(LrSel), 8'(LrSys));
   endtask

   // Inputs for this cycle, then sample mid cycle
   task automatic driveAndSample(input instrByteT opByte, input flagsT flagsValue);
      OpcodeCondIn = opByte;
      Flags        = flagsValue;
      #4;
      checkValue("CFlag", 8'(CFlag), 8'(cFlagModel));
      checkFixedOutputs();
   endtask

   task automatic checkResetState();
      checkValue("RegWe", 8'(RegWe), 8'h00);
      checkValue("PcWe", 8'(PcWe), 8'h00);
      checkValue("IrWe", 8'(IrWe), 8'h00);
      checkValue("AluWe", 8'(AluWe), 8'h00);
      checkValue("LrWe", 8'(LrWe), 8'h00);
      checkValue("SpWe", 8'(SpWe), 8'h00);
      checkValue("MemEn", 8'(MemEn), 8'h00);
      checkValue("ENB", 8'(ENB), 8'h00);
      checkValue("CFlag", 8'(CFlag), 8'h00);
   endtask

   task automatic checkFetchStep(input int f);
      if (f == 1) begin
         checkValue("nME", 8'(nME), 8'h01);
      end
      checkValue("ALE", 8'(ALE), 8'(f == 1));
      checkValue("PcEn", 8'(PcEn), 8'(f == 1));
      checkValue("MemEn", 8'(MemEn), 8'(f != 1));
      checkValue("ENB", 8'(ENB), 8'(f == 3));
      checkValue("IrWe", 8'(IrWe), 8'(f == 4));
      checkValue("nWE", 8'(nWE), 8'h01);   // Fetch only reads memory
      checkValue("RegWe", 8'(RegWe), 8'h00);
      checkValue("PcWe", 8'(PcWe), 8'h00);
   endtask

   task automatic checkFirstExecute(input int base, input instrByteT opByte);
      logic single;
      single = (patternMem[base + 6] == 8'h01);
      checkValue("AluOp", 8'(AluOp), patternMem[base + 2]);
      checkValue("RegWe", 8'(RegWe), patternMem[base + 3]);
      checkValue("PcSel", 8'(PcSel), patternMem[base + 4]);
      checkValue("PcWe", 8'(PcWe), 8'(single));   // Single-cycle opcodes retire in Exe1
      checkValue("PcEn", 8'(PcEn), 8'(single));
      checkValue("LrWe", 8'(LrWe), 8'(opByte == {BRANCH, RET}));
      checkValue("IrWe", 8'(IrWe), 8'h00);
      if ((opByte[7:3] == ADCI) || (opByte[7:3] == SUCI)) begin
         checkValue("ImmSel", 8'(ImmSel), 8'(ImmShort));
         checkValue("Op2Sel", 8'(Op2Sel), 8'(Op2Imm));
      end
   endtask

   task automatic checkMemoryStep(input int k, input logic isLoad);
      checkValue("RegWe", 8'(RegWe), 8'(isLoad && (k == 5)));
      checkValue("PcWe", 8'(PcWe), 8'(k == 5));
      checkValue("IrWe", 8'(IrWe), 8'h00);
      if (isLoad) begin
         checkValue("ALE", 8'(ALE), 8'(k == 2));   // Address phase
         checkValue("ENB", 8'(ENB), 8'(k == 4));
         checkValue("nWE", 8'(nWE), 8'h01);
         if (k == 5) begin
            checkValue("WdSel", 8'(WdSel), 8'(WdSys));
         end
      end else begin
         checkValue("AluEn", 8'(AluEn), 8'h01);
         checkValue("nOE", 8'(nOE), 8'h01);   // A store never reads memory
      end
   endtask

   initial begin
      int        numLines;
      int        base;
      int        execLen;
      instrByteT opByte;
      flagsT     patFlags;
      logic      isLoad;

      nReset        = 1'b0;
      OpcodeCondIn  = '0;
      Flags         = '0;
      cFlagModel    = 1'b0;
      for (int i = 0; i < MaxLines * FieldsPerLine; i++) begin
         patternMem[i] = '0;   // Zero length ends the list
      end
      $readmemh("testbench/controlPatterns.txt", patternMem);
      numLines = 0;
      while (numLines < MaxLines && patternMem[numLines * FieldsPerLine + 6] != 8'h00) begin
         numLines++;
      end
      if (numLines == 0) begin
         stopWithFailure("No pattern lines could be read from testbench/controlPatterns.txt");
      end
      cycleLimit = numLines * 10 + 20;

      repeat (3) @(posedge Clock);
      #1;
      checkResetState();
      nReset = 1'b1;   // This cycle is the first Fet1

      for (int line = 0; line < numLines; line++) begin
         base     = line * FieldsPerLine;
         opByte   = patternMem[base];
         patFlags = patternMem[base + 1][3:0];
         execLen  = int'(patternMem[base + 6]);
         isLoad   = (opByte[7:3] == LDW);
         for (int f = 1; f <= 4; f++) begin
            driveAndSample(opByte, randomFlags());
            checkFetchStep(f);
            nextDrivePoint();
         end
         driveAndSample(opByte, patFlags);
         checkFirstExecute(base, opByte);
         if (patternMem[base + 5][0]) begin
            cFlagModel = patFlags[FlagC];   // Visible from the next cycle
         end
         nextDrivePoint();
         for (int k = 2; k <= execLen; k++) begin
            driveAndSample(opByte, randomFlags());
            checkMemoryStep(k, isLoad);
            nextDrivePoint();
         end
      end

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/controlPatterns.txt ====
// opcode byte, Exe1 flags, expected AluOp (aluFnT code), RegWe, PcSel, status write, exec cycles
// PcSel codes are 0 Pc1, 1 PcSysbus, 2 PcAluOut
03 2 1 1 0 1 1   // ADD with condition bits set
08 0 1 1 0 1 1   // ADDI
10 f 1 1 0 1 1   // ADDIB
18 9 2 1 0 1 1   // ADC
20 6 2 1 0 1 1   // ADCI
28 4 3 1 0 1 1   // SUB
30 b 3 1 0 1 1   // SUBI
38 1 3 1 0 1 1   // SUBIB
40 e 2 1 0 1 1   // SUC
48 8 2 1 0 1 1   // SUCI
50 7 3 0 0 1 1   // CMP
5d 0 3 0 0 1 1   // CMPI
60 a 5 1 0 1 1   // AND
68 5 6 1 0 1 1   // OR
70 3 7 1 0 1 1   // XOR
78 c 8 1 0 1 1   // NOT
80 2 9 1 0 1 1   // NAND
88 d a 1 0 1 1   // NOR
90 0 4 1 0 1 1   // NEG
98 6 b 1 0 1 1   // LSL
a0 9 c 1 0 1 1   // LSR
a8 2 d 1 0 1 1   // ASR
b0 0 e 1 0 0 1   // LUI, carry must hold
b8 d e 1 0 0 1   // LLI
c0 0 1 0 0 0 5   // LDW
c8 0 1 0 0 0 5   // STW
c5 f 1 0 0 0 5   // LDW again
e6 0 0 0 1 0 1   // RET
e7 f 1 0 2 0 1   // JMP
e1 0 0 0 0 0 1   // Dropped conditional branch
e3 f 0 0 0 0 1   // Dropped conditional branch
d0 0 0 0 0 0 1   // Former PUSH slot
d8 2 0 0 0 0 1   // Former POP slot
f8 0 0 0 0 0 1   // Unlisted opcode
52 0 3 0 0 1 1   // CMP clears carry

// ==== vlog.f ====
common/cpuControlPkg.sv
common/stepIf.sv
hw/cycleSequencer.sv
decode/busCycleDecoder.sv
decode/datapathDecoder.sv
hw/controlTop.sv
testbench/controlTop_properties.sv
testbench/controlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controlTb
FILELIST  ?= vlog.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
FAILMSG   ?= Some tests failed
PASSMSG   ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)
	-./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
